/* i2c_pkg.sv */
// I2C write master shared types: command word, result, bus lines and bit phases
package i2c_pkg;

	// Address byte plus four payload bytes
	localparam int message_bytes = 5;

	// Field view of a command, packed so that byte 0 is the address byte
	typedef struct packed {
		logic [31:0] payload;
		logic [6:0] address;
		logic read_write;
	} i2c_write_fields_t;

	// Sender fills the fields, serializer walks the bytes
	typedef union packed {
		i2c_write_fields_t fields;
		logic [message_bytes-1:0][7:0] bytes;
	} i2c_command_t;

	typedef struct packed {
		logic acked;
		logic [2:0] bytes_acked;
	} i2c_result_t;

	// Used both for line levels and for drive-low enables
	typedef struct packed {
		logic scl;
		logic sda;
	} i2c_lines_t;

	// Quarter-bit phases, named by the SCL level they produce
	typedef enum logic [1:0] {
		scl_low_a,
		scl_low_b,
		scl_high_a,
		scl_high_b
	} i2c_phase_t;

endpackage

/* i2c_phase_timer.sv */
// Quarter-bit phase timer: divides the clock into ticks and steps the bit phase
`timescale 1ns/1ps

module i2c_phase_timer
	import i2c_pkg::*;
#(
	parameter int clock_divider = 4
) (
	input logic clock,
	input logic reset,
	input logic run,
	output logic tick,
	output i2c_phase_t phase
);

	localparam int count_width = (clock_divider > 1) ? $clog2(clock_divider) : 1;

	logic [count_width-1:0] count;

	assign tick = run && (count == '0);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			count <= count_width'(clock_divider - 1);
			phase <= scl_low_a;
		end else if (!run) begin
			// Idle between transfers, so the next one starts in scl_low_a
			count <= count_width'(clock_divider - 1);
			phase <= scl_low_a;
		end else if (tick) begin
			count <= count_width'(clock_divider - 1);
			phase <= i2c_phase_t'(phase + 2'd1);
		end else begin
			count <= count - 1'b1;
		end
	end

endmodule

/* i2c_line_monitor.sv */
// I2C line monitor: synchronises and filters SCL/SDA and tracks bus busy
`timescale 1ns/1ps

module i2c_line_monitor
	import i2c_pkg::*;
(
	input logic clock,
	input logic reset,
	input i2c_lines_t lines_in,
	output i2c_lines_t lines,
	output logic bus_busy
);

	i2c_lines_t sync_a;
	i2c_lines_t sync_b;
	i2c_lines_t hist_a;
	i2c_lines_t hist_b;
	i2c_lines_t last_lines;
	logic [1:0] agree;
	logic start_seen;
	logic stop_seen;

	// A line is accepted once three samples in a row match
	assign agree = ~(sync_b ^ hist_a) & ~(hist_a ^ hist_b);

	assign start_seen = last_lines.scl && lines.scl && last_lines.sda && !lines.sda;
	assign stop_seen = last_lines.scl && lines.scl && !last_lines.sda && lines.sda;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			sync_a <= '1;
			sync_b <= '1;
			hist_a <= '1;
			hist_b <= '1;
			lines <= '1;
			last_lines <= '1;
			bus_busy <= 1'b0;
		end else begin
			sync_a <= lines_in;
			sync_b <= sync_a;
			hist_a <= sync_b;
			hist_b <= hist_a;
			lines <= (lines & ~agree) | (sync_b & agree);
			last_lines <= lines;
			// Our own start and stop count too
			if (start_seen)
				bus_busy <= 1'b1;
			else if (stop_seen)
				bus_busy <= 1'b0;
		end
	end

endmodule

/* i2c_command_queue.sv */
// Command queue: circular FIFO of write commands with credit return on pop
`timescale 1ns/1ps

module i2c_command_queue
	import i2c_pkg::*;
#(
	parameter int queue_depth = 2
) (
	input logic clock,
	input logic reset,
	input logic command_valid,
	input i2c_command_t command,
	input logic pop,
	output i2c_command_t head,
	output logic not_empty,
	output logic credit_return
);

	localparam int ptr_width = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int count_width = $clog2(queue_depth + 1);

	i2c_command_t storage [queue_depth];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic [count_width-1:0] count;
	logic full;

	assign head = storage[rd_ptr];
	assign not_empty = (count != '0);
	assign full = (count == count_width'(queue_depth));

	always_ff @(posedge clock) begin
		if (command_valid)
			storage[wr_ptr] <= command;
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			// Credit goes back one cycle after the slot is freed
			credit_return <= pop;
			if (command_valid)
				wr_ptr <= (wr_ptr == ptr_width'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_width'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
			case ({command_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Sender must respect its credits
	assert property (@(posedge clock) disable iff (reset) command_valid |-> !full);

	// Sequencer only pops a waiting command
	assert property (@(posedge clock) disable iff (reset) pop |-> not_empty);

endmodule

/* i2c_byte_serializer.sv */
// Byte serializer: holds the active command and presents its bits MSB first
`timescale 1ns/1ps

module i2c_byte_serializer
	import i2c_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic load,
	input i2c_command_t command,
	input logic next_bit,
	output logic current_bit,
	output logic last_bit_of_byte,
	output logic last_byte,
	output logic [2:0] bytes_sent
);

	i2c_command_t command_reg;
	logic [2:0] bit_index;
	logic [2:0] byte_index;

	assign current_bit = command_reg.bytes[byte_index][bit_index];
	assign last_bit_of_byte = (bit_index == 3'd0);
	assign last_byte = (byte_index == 3'(message_bytes - 1));
	assign bytes_sent = byte_index;

	always_ff @(posedge clock) begin
		if (load)
			command_reg <= command;
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			bit_index <= 3'd7;
			byte_index <= 3'd0;
		end else if (load) begin
			bit_index <= 3'd7;
			byte_index <= 3'd0;
		end else if (next_bit) begin
			// Past bit 0 moves on to the next byte
			if (bit_index == 3'd0) begin
				bit_index <= 3'd7;
				byte_index <= byte_index + 3'd1;
			end else begin
				bit_index <= bit_index - 3'd1;
			end
		end
	end

endmodule

/* i2c_write_sequencer.sv */
// I2C write sequencer: FSM that runs start, data, ack and stop for each command
`timescale 1ns/1ps

module i2c_write_sequencer
	import i2c_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic not_empty,
	input i2c_command_t head,
	output logic pop,
	input i2c_lines_t lines,
	input logic bus_busy,
	input logic tick,
	input i2c_phase_t phase,
	output logic run,
	output logic load,
	output logic next_bit,
	input logic current_bit,
	input logic last_bit_of_byte,
	input logic last_byte,
	input logic [2:0] bytes_sent,
	output i2c_lines_t drive_low,
	output logic result_valid,
	output i2c_result_t result
);

	typedef enum logic [2:0] {
		idle,
		start,
		data_bit,
		ack_bit,
		stop,
		report
	} state_t;

	state_t state;
	logic begin_transfer;
	logic clocked_state;
	logic sda_update;
	logic ack_sample;
	logic final_ack;

	assign begin_transfer = (state == idle) && not_empty && !bus_busy;
	assign pop = begin_transfer;
	assign load = begin_transfer;
	assign run = (state != idle) && (state != report);
	assign result_valid = (state == report);

	// States that toggle SCL through all four phases
	assign clocked_state = (state == data_bit) || (state == ack_bit) || (state == stop);

	assign ack_sample = (state == ack_bit) && tick && (phase == scl_high_b);
	// High SDA in the ack slot is a NACK
	assign final_ack = lines.sda || last_byte;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= idle;
			drive_low <= '0;
			sda_update <= 1'b0;
			next_bit <= 1'b0;
		end else begin
			sda_update <= 1'b0;
			next_bit <= 1'b0;

			// SDA moves one cycle after SCL has been pulled low
			if (sda_update) begin
				case (state)
					data_bit: drive_low.sda <= ~current_bit;
					stop: drive_low.sda <= 1'b1;
					default: drive_low.sda <= 1'b0;
				endcase
			end

			if (tick && clocked_state) begin
				if (phase == scl_low_a) begin
					drive_low.scl <= 1'b1;
					sda_update <= 1'b1;
				end else if (phase == scl_high_a) begin
					drive_low.scl <= 1'b0;
				end
			end

			case (state)
				idle: begin
					if (begin_transfer)
						state <= start;
				end
				start: begin
					// SDA falls with SCL released, SCL follows a phase later
					if (tick && phase == scl_low_a)
						drive_low.sda <= 1'b1;
					if (tick && phase == scl_low_b)
						drive_low.scl <= 1'b1;
					if (tick && phase == scl_high_b)
						state <= data_bit;
				end
				data_bit: begin
					if (tick && phase == scl_high_b) begin
						if (last_bit_of_byte)
							state <= ack_bit;
						else
							next_bit <= 1'b1;
					end
				end
				ack_bit: begin
					if (ack_sample) begin
						if (final_ack) begin
							state <= stop;
						end else begin
							next_bit <= 1'b1;
							state <= data_bit;
						end
					end
				end
				stop: begin
					// Releasing SDA with SCL high is the stop condition
					if (tick && phase == scl_high_b) begin
						drive_low.sda <= 1'b0;
						state <= report;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (ack_sample && final_ack) begin
			result.acked <= !lines.sda;
			result.bytes_acked <= lines.sda ? bytes_sent : 3'(message_bytes);
		end
	end

	// Only write commands reach the bus
	assert property (@(posedge clock) disable iff (reset)
		pop |-> (head.fields.read_write == 1'b0));

	// With SCL released, SDA may only move for start and stop
	assert property (@(posedge clock) disable iff (reset)
		$changed(drive_low.sda) |-> $past(drive_low.scl) || $past(state) inside {start, stop});

endmodule

/* i2c_write_master.sv */
// I2C write master top level: queue, serializer, sequencer, timer and line monitor
`timescale 1ns/1ps

module i2c_write_master
	import i2c_pkg::*;
#(
	parameter int clock_divider = 4,
	parameter int queue_depth = 2
) (
	input logic clock,
	input logic reset,
	input logic command_valid,
	input i2c_command_t command,
	output logic credit_return,
	input i2c_lines_t lines_in,
	output i2c_lines_t drive_low,
	output logic result_valid,
	output i2c_result_t result
);

	i2c_command_t head;
	logic not_empty;
	logic pop;
	logic load;
	logic next_bit;
	logic current_bit;
	logic last_bit_of_byte;
	logic last_byte;
	logic [2:0] bytes_sent;
	logic run;
	logic tick;
	i2c_phase_t phase;
	i2c_lines_t lines;
	logic bus_busy;

	i2c_command_queue #(
		.queue_depth(queue_depth)
	) i2c_command_queue_i (
		.clock(clock),
		.reset(reset),
		.command_valid(command_valid),
		.command(command),
		.pop(pop),
		.head(head),
		.not_empty(not_empty),
		.credit_return(credit_return)
	);

	i2c_byte_serializer i2c_byte_serializer_i (
		.clock(clock),
		.reset(reset),
		.load(load),
		.command(head),
		.next_bit(next_bit),
		.current_bit(current_bit),
		.last_bit_of_byte(last_bit_of_byte),
		.last_byte(last_byte),
		.bytes_sent(bytes_sent)
	);

	i2c_phase_timer #(
		.clock_divider(clock_divider)
	) i2c_phase_timer_i (
		.clock(clock),
		.reset(reset),
		.run(run),
		.tick(tick),
		.phase(phase)
	);

	i2c_line_monitor i2c_line_monitor_i (
		.clock(clock),
		.reset(reset),
		.lines_in(lines_in),
		.lines(lines),
		.bus_busy(bus_busy)
	);

	i2c_write_sequencer i2c_write_sequencer_i (
		.clock(clock),
		.reset(reset),
		.not_empty(not_empty),
		.head(head),
		.pop(pop),
		.lines(lines),
		.bus_busy(bus_busy),
		.tick(tick),
		.phase(phase),
		.run(run),
		.load(load),
		.next_bit(next_bit),
		.current_bit(current_bit),
		.last_bit_of_byte(last_bit_of_byte),
		.last_byte(last_byte),
		.bytes_sent(bytes_sent),
		.drive_low(drive_low),
		.result_valid(result_valid),
		.result(result)
	);

endmodule

/* tb_i2c_write_master.sv */
// Testbench for the I2C write master: trace-driven sender, slave model and bus checks
`timescale 1ns/1ps

module tb_i2c_write_master
	import i2c_pkg::*;
();

	localparam int clock_divider = 4;
	localparam int queue_depth = 2;
	localparam int max_lines = 16;
	localparam int no_nack = 7;

	// One byte of the command's byte view
	typedef logic [7:0] command_byte_t;

	logic clock;
	logic reset;
	logic command_valid;
	i2c_command_t command;
	logic credit_return;
	i2c_lines_t lines_in;
	i2c_lines_t drive_low;
	logic result_valid;
	i2c_result_t result;

	logic [31:0] trace_mem [0:4*max_lines-1];
	i2c_command_t commands [max_lines];
	int nack_at [max_lines];
	logic foreign_first [max_lines];
	int line_count;
	logic trace_ready;

	logic slave_sda_low;
	logic slave_next;
	logic foreign_scl_low;
	logic foreign_sda_low;
	logic foreign_active;

	// Bus watcher state, sampled on the falling clock edge
	i2c_lines_t prev_lines;
	logic bus_open;
	logic slave_open;
	logic in_ack;
	int bit_count;
	int byte_index;
	command_byte_t shift;
	int transfers;

	int sent;
	int returns;
	int results;
	int mismatches;
	int failures;

	// Open-drain wired-AND of master, slave and foreign master
	assign lines_in.scl = !(drive_low.scl || foreign_scl_low);
	assign lines_in.sda = !(drive_low.sda || slave_sda_low || foreign_sda_low);

	i2c_write_master #(
		.clock_divider(clock_divider),
		.queue_depth(queue_depth)
	) i2c_write_master_i (
		.clock(clock),
		.reset(reset),
		.command_valid(command_valid),
		.command(command),
		.credit_return(credit_return),
		.lines_in(lines_in),
		.drive_low(drive_low),
		.result_valid(result_valid),
		.result(result)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Slave reacts one edge after it sees the bus
	initial begin
		slave_sda_low = 1'b0;
		forever begin
			@(posedge clock);
			#2;
			slave_sda_low = slave_next;
		end
	end

	function automatic i2c_result_t expected_result(input int nack);
		i2c_result_t r;
		r.acked = (nack == no_nack);
		r.bytes_acked = (nack == no_nack) ? 3'(message_bytes) : 3'(nack);
		return r;
	endfunction

	task automatic note_failure(input string what);
		failures++;
		$display("ERROR %0t: %s", $time, what);
	endtask

	task automatic check_result(input i2c_result_t actual, input i2c_result_t expected);
		if (actual !== expected) begin
			mismatches++;
			$display("MISMATCH %0t: result got acked=%0b bytes_acked=%0d, expected acked=%0b bytes_acked=%0d",
				$time, actual.acked, actual.bytes_acked, expected.acked, expected.bytes_acked);
		end
	endtask

	task automatic check_byte(input string name, input command_byte_t actual,
		input command_byte_t expected);
		if (actual !== expected) begin
			mismatches++;
			$display("MISMATCH %0t: %s got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// Waits for a credit, then offers the command for one cycle
	task automatic push_command(input int index);
		while (sent >= queue_depth + returns) begin
			command_valid = 1'b0;
			@(posedge clock);
			#2;
		end
		command_valid = 1'b1;
		command = commands[index];
		sent++;
		@(posedge clock);
		#2;
	endtask

	// Foreign master takes the bus, the command is queued while it holds it
	task automatic hold_bus_then_push(input int index);
		command_valid = 1'b0;
		wait (results == sent);
		repeat (20) @(posedge clock);
		#2;
		foreign_active = 1'b1;
		foreign_sda_low = 1'b1;
		repeat (5) @(posedge clock);
		#2;
		foreign_scl_low = 1'b1;
		repeat (5) @(posedge clock);
		#2;
		push_command(index);
		command_valid = 1'b0;
		repeat (40) @(posedge clock);
		#2;
		foreign_scl_low = 1'b0;
		repeat (5) @(posedge clock);
		#2;
		foreign_sda_low = 1'b0;
		foreign_active = 1'b0;
	endtask

	// Start/stop bookkeeping and the slave's byte capture and acknowledge
	task automatic watch_bus();
		logic start_cond;
		logic stop_cond;
		int expected_count;
		start_cond = prev_lines.scl && lines_in.scl && prev_lines.sda && !lines_in.sda;
		stop_cond = prev_lines.scl && lines_in.scl && !prev_lines.sda && lines_in.sda;
		if (start_cond) begin
			if (bus_open)
				note_failure("start condition inside an open transfer");
			bus_open = 1'b1;
			if (!foreign_active) begin
				slave_open = 1'b1;
				in_ack = 1'b0;
				bit_count = 0;
				byte_index = 0;
			end
		end else if (stop_cond) begin
			if (!bus_open)
				note_failure("stop condition with no open transfer");
			bus_open = 1'b0;
			if (slave_open && transfers < line_count) begin
				expected_count = (nack_at[transfers] == no_nack) ? message_bytes
					: nack_at[transfers] + 1;
				if (byte_index != expected_count) begin
					mismatches++;
					$display("MISMATCH %0t: bytes on bus got %0d, expected %0d",
						$time, byte_index, expected_count);
				end
			end
			if (slave_open)
				transfers++;
			slave_open = 1'b0;
			slave_next = 1'b0;
		end else if (slave_open && !prev_lines.scl && lines_in.scl && !in_ack) begin
			shift = {shift[6:0], lines_in.sda};
			bit_count++;
		end else if (slave_open && prev_lines.scl && !lines_in.scl) begin
			if (in_ack) begin
				slave_next = 1'b0;
				in_ack = 1'b0;
				bit_count = 0;
				byte_index++;
			end else if (bit_count == 8) begin
				if (transfers >= line_count) begin
					note_failure("bus transfer beyond the end of the trace");
				end else if (byte_index >= message_bytes || byte_index > nack_at[transfers]) begin
					note_failure("byte sent after a NACK or past the last byte");
				end else begin
					check_byte($sformatf("bus byte %0d of command %0d", byte_index, transfers),
						shift, commands[transfers].bytes[byte_index]);
					slave_next = (byte_index != nack_at[transfers]);
				end
				in_ack = 1'b1;
			end
		end
	endtask

	always @(negedge clock) begin
		if (!reset) begin
			watch_bus();
			if (credit_return)
				returns++;
			if (foreign_active && drive_low !== '0)
				note_failure("master drove the bus while a foreign master held it");
			if (result_valid) begin
				if (results >= line_count)
					note_failure("result with no command outstanding");
				else if (transfers <= results)
					note_failure("result came before its stop condition");
				else
					check_result(result, expected_result(nack_at[results]));
				results++;
			end
		end
		prev_lines = lines_in;
	end

	initial begin
		wait (trace_ready);
		#(line_count * message_bytes * 9 * 4 * clock_divider * 40 * 2 + 20000);
		$display("Watchdog expired with %0d of %0d results received", results, line_count);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		reset = 1'b1;
		command_valid = 1'b0;
		command = '0;
		slave_next = 1'b0;
		foreign_scl_low = 1'b0;
		foreign_sda_low = 1'b0;
		foreign_active = 1'b0;
		prev_lines = '1;
		bus_open = 1'b0;
		slave_open = 1'b0;
		in_ack = 1'b0;
		bit_count = 0;
		byte_index = 0;
		shift = '0;
		transfers = 0;
		sent = 0;
		returns = 0;
		results = 0;
		mismatches = 0;
		failures = 0;
		line_count = 0;
		trace_ready = 1'b0;

		// Unused slots keep a non-address word so the end of the trace is found
		for (int i = 0; i < 4 * max_lines; i++)
			trace_mem[i] = {16'hdead, 16'(i)};
		$readmemh("i2c_write_trace.txt", trace_mem);
		while (line_count < max_lines && trace_mem[4 * line_count] <= 32'h7f) begin
			commands[line_count].fields.address = trace_mem[4 * line_count][6:0];
			commands[line_count].fields.read_write = 1'b0;
			commands[line_count].fields.payload = trace_mem[4 * line_count + 1];
			nack_at[line_count] = int'(trace_mem[4 * line_count + 2]);
			foreign_first[line_count] = trace_mem[4 * line_count + 3][0];
			line_count++;
		end
		trace_ready = 1'b1;
		if (line_count == 0)
			note_failure("trace file holds no commands");

		repeat (4) @(posedge clock);
		#2;
		if (drive_low !== '0 || result_valid !== 1'b0 || credit_return !== 1'b0)
			note_failure("outputs active during reset");
		reset = 1'b0;
		@(negedge clock);
		if (drive_low !== '0 || result_valid !== 1'b0 || credit_return !== 1'b0)
			note_failure("outputs active right after reset");
		@(posedge clock);
		#2;

		for (int i = 0; i < line_count; i++) begin
			if (foreign_first[i])
				hold_bus_then_push(i);
			else
				push_command(i);
		end
		command_valid = 1'b0;

		wait (results == line_count);
		repeat (40) @(posedge clock);
		if (returns != sent)
			note_failure($sformatf("only %0d of %0d credits came back", returns, sent));
		if (transfers != line_count)
			note_failure($sformatf("saw %0d bus transfers for %0d commands", transfers, line_count));
		if (bus_open)
			note_failure("bus left without a stop condition");

		$display("Done: %0d commands, %0d results, %0d mismatches, %0d other failures",
			line_count, results, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* i2c_write_trace.txt */
// Columns (hex): device address, 32-bit payload, byte to NACK (7 = none), foreign start/stop first
// One write command per line, sent in order
50 12345678 7 0
23 a5c3f00f 7 0
11 deadbeef 0 0
3c 0badf00d 2 0
7f ffffffff 7 0
00 00000000 7 0
48 cafe1234 7 1
2a 5a5aa5a5 4 0
61 87654321 7 0
05 13579bdf 1 1
3e 2468ace0 7 0
19 0f1e2d3c 3 0

/* sources.f */
i2c_pkg.sv
i2c_phase_timer.sv
i2c_line_monitor.sv
i2c_command_queue.sv
i2c_byte_serializer.sv
i2c_write_sequencer.sv
i2c_write_master.sv
tb_i2c_write_master.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_i2c_write_master
FILELIST = sources.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
